// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_gb_exec
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FLIST))
HEADERS := $(wildcard hdl/*.svh)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SOURCES) $(HEADERS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@grep -q '^RESULT: PASS$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== flist.f ====
+incdir+hdl
hdl/gb_alu_pkg.sv
hdl/alu.sv
hdl/issue_stage.sv
hdl/reg_file.sv
hdl/writeback.sv
hdl/gb_exec_top.sv
tests/exec_checker.sv
tests/tb_gb_exec.sv

// ==== hdl/alu.sv ====
`timescale 1ns/100ps
`include "gb_alu_macros.svh"

module alu import gb_alu_pkg::*; (
	input  logic [`GB_DATA_W-1:0] op_a,
	input  logic [`GB_DATA_W-1:0] op_b,
	input  alu_op_t               op_code,
	input  gb_flags_t             curr_flags,
	output logic                  pc_inc_h,
	output logic                  pc_dec_h,
	output logic                  sp_inc_h,
	output logic                  sp_dec_h,
	output gb_flags_t             next_flags,
	output logic [`GB_DATA_W-1:0] alu_result,
	output logic [`GB_ADDR_W-1:0] addr_result
);

	logic [`GB_DATA_W:0]   sum;
	logic [`GB_DATA_W-1:0] daa_adj;
	logic [`GB_ADDR_W-1:0] ads_sum;

	always_comb begin
		alu_result = '0;
		addr_result = '0;
		next_flags = curr_flags;
		pc_inc_h = 1'b0;
		pc_dec_h = 1'b0;
		sp_inc_h = 1'b0;
		sp_dec_h = 1'b0;
		sum = '0;
		daa_adj = '0;

		case (op_code)
			alu_ab: addr_result = {op_a, op_b};
			alu_b: alu_result = op_b;
			alu_add, alu_adc: begin
				sum = {1'b0, op_a} + {1'b0, op_b}
					+ {8'b0, (op_code == alu_adc) & curr_flags.c};
				alu_result = sum[7:0];
				next_flags.z = (sum[7:0] == '0);
				next_flags.n = 1'b0;
				next_flags.h = sum[4] ^ op_a[4] ^ op_b[4];
				next_flags.c = sum[8];
			end
			alu_sub, alu_sbc: begin
				// Bit 8 of the difference is the borrow
				sum = {1'b0, op_a} - {1'b0, op_b}
					- {8'b0, (op_code == alu_sbc) & curr_flags.c};
				alu_result = sum[7:0];
				next_flags.z = (sum[7:0] == '0);
				next_flags.n = 1'b1;
				next_flags.h = sum[4] ^ op_a[4] ^ op_b[4];
				next_flags.c = sum[8];
			end
			alu_ads_pc: begin
				sum = {1'b0, op_a} + {1'b0, op_b};
				alu_result = sum[7:0];
				pc_inc_h = ~op_b[7] & sum[8];
				pc_dec_h = op_b[7] & ~sum[8];
			end
			alu_ads_sp: begin
				sum = {1'b0, op_a} + {1'b0, op_b};
				alu_result = sum[7:0];
				sp_inc_h = ~op_b[7] & sum[8];
				sp_dec_h = op_b[7] & ~sum[8];
				{next_flags.z, next_flags.n} = 2'b00;
				next_flags.h = sum[4] ^ op_a[4] ^ op_b[4];
				next_flags.c = sp_inc_h | sp_dec_h;
			end
			alu_and, alu_or, alu_xor: begin
				case (op_code)
					alu_and: alu_result = op_a & op_b;
					alu_or:  alu_result = op_a | op_b;
					default: alu_result = op_a ^ op_b;
				endcase
				next_flags.z = (alu_result == '0);
				next_flags.n = 1'b0;
				next_flags.h = (op_code == alu_and);
				next_flags.c = 1'b0;
			end
			alu_inc, alu_dec: begin
				alu_result = (op_code == alu_inc) ? op_b + 8'h01 : op_b - 8'h01;
				next_flags.z = (alu_result == '0);
				next_flags.n = (op_code == alu_dec);
				next_flags.h = alu_result[4] ^ op_b[4];
			end
			alu_swap: begin
				alu_result = {op_b[3:0], op_b[7:4]};
				next_flags = '{z: (alu_result == '0), default: 1'b0};
			end
			alu_daa: begin
				if (curr_flags.n) begin
					daa_adj = {curr_flags.c ? 4'h6 : 4'h0, curr_flags.h ? 4'h6 : 4'h0};
					alu_result = op_b - daa_adj;
				end else begin
					if (curr_flags.h || op_b[3:0] > 4'h9)
						daa_adj[3:0] = 4'h6;
					if (curr_flags.c || op_b > 8'h99)
						daa_adj[7:4] = 4'h6;
					alu_result = op_b + daa_adj;
					next_flags.c = curr_flags.c | (op_b > 8'h99);
				end
				next_flags.z = (alu_result == '0);
				next_flags.h = 1'b0;
			end
			alu_cpl: begin
				alu_result = ~op_b;
				{next_flags.n, next_flags.h} = 2'b11;
			end
			// A forms of the rotates always clear Z
			alu_rlc, alu_rlca: begin
				{next_flags.c, alu_result} = {op_b, op_b[7]};
				next_flags.z = (op_code == alu_rlc) && (alu_result == '0);
				{next_flags.n, next_flags.h} = 2'b00;
			end
			alu_rl, alu_rla: begin
				{next_flags.c, alu_result} = {op_b, curr_flags.c};
				next_flags.z = (op_code == alu_rl) && (alu_result == '0);
				{next_flags.n, next_flags.h} = 2'b00;
			end
			alu_rrc, alu_rrca: begin
				{next_flags.c, alu_result} = {op_b[0], op_b[0], op_b[7:1]};
				next_flags.z = (op_code == alu_rrc) && (alu_result == '0);
				{next_flags.n, next_flags.h} = 2'b00;
			end
			alu_rr, alu_rra: begin
				{next_flags.c, alu_result} = {op_b[0], curr_flags.c, op_b[7:1]};
				next_flags.z = (op_code == alu_rr) && (alu_result == '0);
				{next_flags.n, next_flags.h} = 2'b00;
			end
			alu_sla, alu_sra, alu_srl: begin
				case (op_code)
					alu_sla: {next_flags.c, alu_result} = {op_b, 1'b0};
					alu_sra: {next_flags.c, alu_result} = {op_b[0], op_b[7], op_b[7:1]};
					default: {next_flags.c, alu_result} = {op_b[0], 1'b0, op_b[7:1]};
				endcase
				next_flags.z = (alu_result == '0);
				{next_flags.n, next_flags.h} = 2'b00;
			end
			alu_incl: addr_result = {op_a, op_b} + 16'd1;
			alu_decl: addr_result = {op_a, op_b} - 16'd1;
			alu_scf: next_flags = '{z: curr_flags.z, n: 1'b0, h: 1'b0, c: 1'b1};
			alu_ccf: next_flags = '{z: curr_flags.z, n: 1'b0, h: 1'b0, c: ~curr_flags.c};
			default: ;
		endcase
	end

	// Low byte plus the sign-extended offset, high byte moves by at most one
	assign ads_sum = {{`GB_DATA_W{1'b0}}, op_a} + {{`GB_DATA_W{op_b[7]}}, op_b};

	// Strobes match the high byte of the full 16-bit offset add
	always_comb begin
		if (op_code == alu_ads_pc || op_code == alu_ads_sp) begin
			assert ((pc_inc_h | sp_inc_h) == (ads_sum[15:8] == 8'h01)
				&& (pc_dec_h | sp_dec_h) == (ads_sum[15:8] == 8'hff))
				else $error("alu: high-byte strobes disagree with the offset add");
		end
	end

endmodule

// ==== hdl/gb_alu_macros.svh ====
`ifndef GB_ALU_MACROS_SVH
`define GB_ALU_MACROS_SVH

// Byte and pair widths
`define GB_DATA_W 8
`define GB_ADDR_W 16

// A, F', B, C, D, E, H, L
`define GB_NUM_REGS 8
`define GB_REG_IDX_W 3

`endif

// ==== hdl/gb_alu_pkg.sv ====
`include "gb_alu_macros.svh"

package gb_alu_pkg;

	// Order is fixed, the test data file uses the numeric codes
	typedef enum logic [4:0] {
		alu_nop, alu_ab, alu_b, alu_add,
		alu_adc, alu_ads_pc, alu_ads_sp, alu_sub,
		alu_sbc, alu_and, alu_or, alu_xor,
		alu_inc, alu_dec, alu_swap, alu_daa,
		alu_cpl, alu_rlc, alu_rlca, alu_rl,
		alu_rla, alu_rrc, alu_rrca, alu_rr,
		alu_rra, alu_sla, alu_sra, alu_srl,
		alu_incl, alu_decl, alu_scf, alu_ccf
	} alu_op_t;

	typedef struct packed {
		logic z;
		logic n;
		logic h;
		logic c;
	} gb_flags_t;

	// Register pair, seen as one word or as two bytes
	typedef union packed {
		logic [`GB_ADDR_W-1:0] word;
		struct packed {
			logic [`GB_DATA_W-1:0] hi;
			logic [`GB_DATA_W-1:0] lo;
		} bytes;
	} reg_pair_u;

	typedef struct packed {
		alu_op_t                  op;
		logic [`GB_REG_IDX_W-1:0] dst;
		logic [`GB_REG_IDX_W-1:0] src;
		logic                     use_imm;
		logic [`GB_DATA_W-1:0]    imm;
		logic [1:0]               pair;
	} alu_cmd_t;

	typedef struct packed {
		logic [`GB_DATA_W-1:0] data;
		logic [`GB_ADDR_W-1:0] addr;
		gb_flags_t             flags;
	} exec_result_t;

endpackage

// ==== hdl/gb_exec_top.sv ====
`timescale 1ns/100ps
`include "gb_alu_macros.svh"

module gb_exec_top import gb_alu_pkg::*; (
	input  logic         clk,
	input  logic         arst_n,
	input  logic         cmd_valid,
	input  alu_cmd_t     cmd,
	output logic         result_valid,
	output exec_result_t result
);

	logic [`GB_REG_IDX_W-1:0] rd_idx_a, rd_idx_b, wr_idx;
	logic [1:0]               rd_pair, wr_pair;
	logic [`GB_DATA_W-1:0]    rd_byte_a, rd_byte_b, op_a, op_b, alu_result;
	logic [`GB_ADDR_W-1:0]    addr_result;
	reg_pair_u                rd_pair_val, wr_data;
	logic                     issue_valid, we, wr_pair_mode;
	logic                     pc_inc_h, pc_dec_h, sp_inc_h, sp_dec_h;
	alu_cmd_t                 issue_cmd;
	gb_flags_t                curr_flags, next_flags;

	issue_stage issue_stage_i (
		.clk, .arst_n, .cmd_valid, .cmd,
		.rd_idx_a, .rd_idx_b, .rd_pair, .rd_byte_a, .rd_byte_b, .rd_pair_val,
		.issue_valid, .issue_cmd, .op_a, .op_b
	);

	reg_file reg_file_i (
		.clk, .arst_n, .rd_idx_a, .rd_idx_b, .rd_pair,
		.rd_byte_a, .rd_byte_b, .rd_pair_val,
		.we, .wr_pair_mode, .wr_idx, .wr_pair, .wr_data
	);

	alu alu_i (
		.op_a, .op_b, .op_code(issue_cmd.op), .curr_flags,
		.pc_inc_h, .pc_dec_h, .sp_inc_h, .sp_dec_h,
		.next_flags, .alu_result, .addr_result
	);

	writeback writeback_i (
		.clk, .arst_n, .issue_valid, .issue_cmd, .pair_val(rd_pair_val),
		.alu_result, .addr_result, .next_flags,
		.pc_inc_h, .pc_dec_h, .sp_inc_h, .sp_dec_h,
		.curr_flags, .we, .wr_pair_mode, .wr_idx, .wr_pair, .wr_data,
		.result_valid, .result
	);

endmodule

// ==== hdl/issue_stage.sv ====
`timescale 1ns/100ps
`include "gb_alu_macros.svh"

module issue_stage import gb_alu_pkg::*; (
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic                     cmd_valid,
	input  alu_cmd_t                 cmd,
	output logic [`GB_REG_IDX_W-1:0] rd_idx_a,
	output logic [`GB_REG_IDX_W-1:0] rd_idx_b,
	output logic [1:0]               rd_pair,
	input  logic [`GB_DATA_W-1:0]    rd_byte_a,
	input  logic [`GB_DATA_W-1:0]    rd_byte_b,
	input  reg_pair_u                rd_pair_val,
	output logic                     issue_valid,
	output alu_cmd_t                 issue_cmd,
	output logic [`GB_DATA_W-1:0]    op_a,
	output logic [`GB_DATA_W-1:0]    op_b
);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			issue_valid <= 1'b0;
		else
			issue_valid <= cmd_valid;
	end

	always_ff @(posedge clk) begin
		if (cmd_valid)
			issue_cmd <= cmd;
	end

	assign rd_idx_a = issue_cmd.dst;
	assign rd_idx_b = issue_cmd.src;
	assign rd_pair = issue_cmd.pair;

	// Operand select by op class
	always_comb begin
		case (issue_cmd.op)
			alu_incl, alu_decl, alu_ab: {op_a, op_b} = rd_pair_val.word;
			alu_ads_pc, alu_ads_sp: begin
				op_a = rd_pair_val.bytes.lo;
				op_b = issue_cmd.imm;
			end
			default: begin
				op_a = rd_byte_a;
				op_b = issue_cmd.use_imm ? issue_cmd.imm : rd_byte_b;
			end
		endcase
	end

	a_cmd_known: assert property (@(posedge clk) disable iff (!arst_n)
		cmd_valid |-> !$isunknown(cmd))
		else $error("issue_stage: command with unknown bits");

endmodule

// ==== hdl/reg_file.sv ====
`timescale 1ns/100ps
`include "gb_alu_macros.svh"

module reg_file import gb_alu_pkg::*; (
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic [`GB_REG_IDX_W-1:0] rd_idx_a,
	input  logic [`GB_REG_IDX_W-1:0] rd_idx_b,
	input  logic [1:0]               rd_pair,
	output logic [`GB_DATA_W-1:0]    rd_byte_a,
	output logic [`GB_DATA_W-1:0]    rd_byte_b,
	output reg_pair_u                rd_pair_val,
	input  logic                     we,
	input  logic                     wr_pair_mode,
	input  logic [`GB_REG_IDX_W-1:0] wr_idx,
	input  logic [1:0]               wr_pair,
	input  reg_pair_u                wr_data
);

	logic [`GB_NUM_REGS-1:0][`GB_DATA_W-1:0] regs;

	// Even index holds the high byte of a pair
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			regs <= '0;
		end else if (we) begin
			if (wr_pair_mode) begin
				regs[{wr_pair, 1'b0}] <= wr_data.bytes.hi;
				regs[{wr_pair, 1'b1}] <= wr_data.bytes.lo;
			end else begin
				regs[wr_idx] <= wr_data.bytes.lo;
			end
		end
	end

	assign rd_byte_a = regs[rd_idx_a];
	assign rd_byte_b = regs[rd_idx_b];
	assign rd_pair_val.bytes.hi = regs[{rd_pair, 1'b0}];
	assign rd_pair_val.bytes.lo = regs[{rd_pair, 1'b1}];

endmodule

// ==== hdl/writeback.sv ====
`timescale 1ns/100ps
`include "gb_alu_macros.svh"

module writeback import gb_alu_pkg::*; (
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic                     issue_valid,
	input  alu_cmd_t                 issue_cmd,
	input  reg_pair_u                pair_val,
	input  logic [`GB_DATA_W-1:0]    alu_result,
	input  logic [`GB_ADDR_W-1:0]    addr_result,
	input  gb_flags_t                next_flags,
	input  logic                     pc_inc_h,
	input  logic                     pc_dec_h,
	input  logic                     sp_inc_h,
	input  logic                     sp_dec_h,
	output gb_flags_t                curr_flags,
	output logic                     we,
	output logic                     wr_pair_mode,
	output logic [`GB_REG_IDX_W-1:0] wr_idx,
	output logic [1:0]               wr_pair,
	output reg_pair_u                wr_data,
	output logic                     result_valid,
	output exec_result_t             result
);

	reg_pair_u pair_next;
	logic      inc_h;
	logic      dec_h;

	assign inc_h = pc_inc_h | sp_inc_h;
	assign dec_h = pc_dec_h | sp_dec_h;
	assign wr_idx = issue_cmd.dst;
	assign wr_pair = issue_cmd.pair;

	always_comb begin
		we = 1'b0;
		wr_pair_mode = 1'b0;
		wr_data = '0;
		case (issue_cmd.op)
			alu_nop, alu_ab, alu_scf, alu_ccf: ;
			alu_incl, alu_decl: begin
				we = issue_valid;
				wr_pair_mode = 1'b1;
				wr_data.word = addr_result;
			end
			alu_ads_pc, alu_ads_sp: begin
				we = issue_valid;
				wr_pair_mode = 1'b1;
				wr_data.bytes.lo = alu_result;
				wr_data.bytes.hi = pair_val.bytes.hi + {7'b0, inc_h} - {7'b0, dec_h};
			end
			default: begin
				we = issue_valid;
				wr_data.bytes.lo = alu_result;
			end
		endcase
	end

	// Selected pair as it stands after this write
	always_comb begin
		pair_next = pair_val;
		if (wr_pair_mode)
			pair_next = wr_data;
		else if (we && wr_idx[2:1] == wr_pair) begin
			if (wr_idx[0])
				pair_next.bytes.lo = wr_data.bytes.lo;
			else
				pair_next.bytes.hi = wr_data.bytes.lo;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			curr_flags <= '0;
			result_valid <= 1'b0;
		end else begin
			result_valid <= issue_valid;
			if (issue_valid)
				curr_flags <= next_flags;
		end
	end

	always_ff @(posedge clk) begin
		if (issue_valid)
			result <= '{data: alu_result, addr: pair_next.word, flags: next_flags};
	end

	// Only the offset adds may move the high byte of a pair
	a_adjust_ads: assert property (@(posedge clk) disable iff (!arst_n)
		issue_valid && (inc_h || dec_h)
			|-> issue_cmd.op inside {alu_ads_pc, alu_ads_sp})
		else $error("writeback: high-byte adjust outside an offset add");

endmodule

// ==== tests/exec_checker.sv ====
`timescale 1ns/100ps

module exec_checker import gb_alu_pkg::*; (
	input  logic         clk,
	input  logic         arst_n,
	input  logic         exp_valid,
	input  exec_result_t exp_result,
	input  logic         result_valid,
	input  exec_result_t result,
	output int           mismatch_count,
	output int           unexpected_count,
	output int           pending_count
);

	exec_result_t expect_q[$];
	exec_result_t want;
	int           mismatches = 0;
	int           unexpected = 0;
	int           pending = 0;

	assign mismatch_count = mismatches;
	assign unexpected_count = unexpected;
	assign pending_count = pending;

	always @(posedge clk) begin
		if (arst_n) begin
			// Expectation enters two edges before its result
			if (exp_valid)
				expect_q.push_back(exp_result);
			if (result_valid) begin
				if (expect_q.size() == 0) begin
					unexpected++;
					$display("Result at %0t arrived with no command outstanding", $time);
				end else begin
					want = expect_q.pop_front();
					if (result !== want) begin
						mismatches++;
						$display("** Error at %0t: data/addr/flags %h %h %b, expected %h %h %b",
							$time, result.data, result.addr, result.flags,
							want.data, want.addr, want.flags);
					end
				end
			end
			pending = expect_q.size();
		end
	end

endmodule

// ==== tests/exec_input.dat ====
# op dst src use_imm imm pair | expected data addr flags(znhc), all hex
# Registers 0..7 = A F' B C D E H L, pairs 0..3 = AF' BC DE HL
02 0 0 1 3a 0 3a 3a00 0
02 2 0 1 c6 1 c6 c600 0
03 0 2 0 00 0 00 0000 b
04 0 0 1 0f 0 10 1000 2
04 0 0 1 f0 0 00 0000 9
07 0 0 1 01 0 ff ff00 7
08 0 2 0 00 0 38 3800 4
08 0 0 1 38 0 00 0000 c
07 0 0 1 10 0 f0 f000 5
08 0 0 1 0f 0 e0 e000 6
02 0 0 1 5c 0 5c 5c00 6
09 0 0 1 a3 0 00 0000 a
0a 0 2 0 00 0 c6 c600 0
0b 0 0 1 c6 0 00 0000 8
1e 0 0 0 00 0 00 0000 9
10 0 0 0 00 0 ff ff00 f
0e 2 2 0 00 1 6c 6c00 0
02 0 0 1 85 0 85 8500 0
12 0 0 0 00 0 0b 0b00 1
14 0 0 0 00 0 17 1700 0
16 0 0 0 00 0 8b 8b00 1
18 0 0 0 00 0 c5 c500 1
17 0 0 0 00 0 e2 e200 1
19 0 0 0 00 0 c4 c400 1
1a 0 0 0 00 0 e2 e200 0
1b 0 0 0 00 0 71 7100 0
11 0 0 0 00 0 e2 e200 0
15 0 0 0 00 0 71 7100 0
02 0 0 1 80 0 80 8000 0
13 0 0 0 00 0 00 0000 9
16 0 0 0 00 0 00 0000 0
03 0 0 1 15 0 15 1500 0
03 0 0 1 27 0 3c 3c00 0
0f 0 0 0 00 0 42 4200 0
03 0 0 1 0f 0 51 5100 2
0f 0 0 0 00 0 57 5700 0
03 0 0 1 b0 0 07 0700 1
0f 0 0 0 00 0 67 6700 1
03 0 0 1 99 0 00 0000 b
0f 0 0 0 00 0 66 6600 1
07 0 0 1 33 0 33 3300 4
0f 0 0 0 00 0 33 3300 4
07 0 0 1 15 0 1e 1e00 6
0f 0 0 0 00 0 18 1800 4
07 0 0 1 20 0 f8 f800 5
0f 0 0 0 00 0 98 9800 5
07 0 0 1 99 0 ff ff00 7
0f 0 0 0 00 0 99 9900 5
02 2 0 1 ff 1 ff ff00 5
02 3 0 1 ff 1 ff ffff 5
1c 0 0 0 00 1 00 0000 5
1d 0 0 0 00 1 00 ffff 5
1d 0 0 0 00 3 00 ffff 5
02 6 0 1 12 3 12 12ff 5
02 7 0 1 f0 3 f0 12f0 5
05 0 0 1 20 3 10 1310 5
06 0 0 1 e0 3 f0 12f0 1
05 0 0 1 01 1 00 0000 1
06 0 0 1 ff 1 ff ffff 1
01 0 0 0 00 1 00 ffff 1
1f 0 0 0 00 0 00 9900 0
04 0 0 1 01 0 9a 9a00 0
1e 0 0 0 00 0 00 9a00 1
04 0 0 1 01 0 9c 9c00 0
0c 4 4 0 00 2 01 0100 0
03 0 4 0 00 0 9d 9d00 0
0d 5 5 0 00 2 ff 01ff 6
00 0 0 0 00 2 00 01ff 6

// ==== tests/tb_gb_exec.sv ====
`timescale 1ns/100ps

module tb_gb_exec import gb_alu_pkg::*; ();

	logic         clk;
	logic         arst_n;
	logic         cmd_valid;
	alu_cmd_t     cmd;
	logic         result_valid;
	exec_result_t result;
	logic         exp_valid;
	exec_result_t exp_result;
	int           mismatch_count;
	int           unexpected_count;
	int           pending_count;

	gb_exec_top gb_exec_top_i (
		.clk, .arst_n, .cmd_valid, .cmd, .result_valid, .result
	);

	exec_checker exec_checker_i (
		.clk, .arst_n, .exp_valid, .exp_result, .result_valid, .result,
		.mismatch_count, .unexpected_count, .pending_count
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial begin
		int         fd;
		int         n;
		int         gap;
		int         wait_cycles;
		int         cmd_count;
		string      line;
		logic [7:0] f_op, f_dst, f_src, f_use, f_imm, f_pair, f_data, f_flags;
		logic [15:0] f_addr;

		arst_n = 1'b0;
		cmd_valid = 1'b0;
		cmd = '0;
		exp_valid = 1'b0;
		exp_result = '0;
		cmd_count = 0;
		void'($urandom(7164));

		repeat (8) @(posedge clk);
		arst_n <= 1'b1;
		@(posedge clk);

		fd = $fopen("tests/exec_input.dat", "r");
		if (fd == 0)
			$display("Cannot open tests/exec_input.dat, no commands were run");
		else begin
			while ($fgets(line, fd) != 0) begin
				n = 0;
				if (line.len() > 1 && line[0] != "#")
					n = $sscanf(line, "%h %h %h %h %h %h %h %h %h", f_op, f_dst, f_src,
						f_use, f_imm, f_pair, f_data, f_addr, f_flags);
				if (n == 9) begin
					@(posedge clk);
					cmd_valid <= 1'b1;
					cmd <= '{op: alu_op_t'(f_op[4:0]), dst: f_dst[2:0], src: f_src[2:0],
						use_imm: f_use[0], imm: f_imm, pair: f_pair[1:0]};
					exp_valid <= 1'b1;
					exp_result <= '{data: f_data, addr: f_addr, flags: gb_flags_t'(f_flags[3:0])};
					cmd_count++;
					// Occasional idle gap, otherwise back to back
					if ($urandom % 5 == 0) begin
						gap = 1 + $urandom % 3;
						repeat (gap) begin
							@(posedge clk);
							cmd_valid <= 1'b0;
							exp_valid <= 1'b0;
						end
					end
				end
			end
			$fclose(fd);
		end
		@(posedge clk);
		cmd_valid <= 1'b0;
		exp_valid <= 1'b0;

		// Drain the outstanding results
		wait_cycles = 0;
		@(negedge clk);
		while (pending_count != 0 && wait_cycles < 100) begin
			@(negedge clk);
			wait_cycles++;
		end
		if (pending_count != 0)
			$display("Timeout: %0d results still missing after 100 cycles", pending_count);
		repeat (2) @(negedge clk);

		$display("Done: %0d commands, %0d mismatches, %0d unexpected, %0d missing",
			cmd_count, mismatch_count, unexpected_count, pending_count);
		if (cmd_count > 0 && mismatch_count == 0 && unexpected_count == 0
			&& pending_count == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule
